// ==== common/pipePkg.sv ====
package pipePkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_e;

    typedef enum logic {srcRs1, srcPc} srcASel_e;
    typedef enum logic {srcRs2, srcImm} srcBSel_e;

    typedef struct packed {
        aluOp_e      aluOp;
        srcASel_e    srcASel;
        srcBSel_e    srcBSel;
        logic        usesRs1;
        logic        usesRs2;
        logic        regWr;
        logic        illegal;
        logic [31:0] imm;
    } ctrl_t;

    typedef struct packed {
        rvIsaPkg::instWord_u inst;
        logic [31:0]         pc;
    } fetchPkt_t;

    // decode to execute payload
    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        logic [4:0]  rd;
    } issuePkt_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        regWr;
        logic        illegal;
    } resultPkt_t;

endpackage

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

    // major opcodes of the supported subset
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // the alt funct7 selects sub and sra
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    // one instruction word seen through each format
    typedef union packed {
        rType_t rType;
        iType_t iType;
        uType_t uType;
    } instWord_u;

endpackage

// ==== decode/decodeStage.sv ====
module decodeStage (
    input  logic                clk,
    input  logic                rstN_i,
    // fetch stream
    input  logic                fetchValid_i,
    output logic                fetchReady_o,
    input  pipePkg::fetchPkt_t  fetch_i,
    // register file read
    output logic [4:0]          rs1Addr_o,
    output logic [4:0]          rs2Addr_o,
    input  logic [31:0]         rs1Data_i,
    input  logic [31:0]         rs2Data_i,
    // write tracker
    input  logic                hazard_i,
    input  logic                trackFull_i,
    output logic                useRs1_o,
    output logic                useRs2_o,
    output logic                push_o,
    output logic [4:0]          pushRd_o,
    // issue stream to execute
    output logic                issueValid_o,
    input  logic                issueReady_i,
    output pipePkg::issuePkt_t  issue_o
);

    pipePkg::ctrl_t ctrlD;
    pipePkg::issuePkt_t issueD;
    logic canAccept;
    logic accept;

    instDecoder uDecoder (
        .inst_i (fetch_i.inst),
        .ctrl_o (ctrlD)
    );

    assign rs1Addr_o = fetch_i.inst.rType.rs1;
    assign rs2Addr_o = fetch_i.inst.rType.rs2;
    assign useRs1_o = ctrlD.usesRs1;
    assign useRs2_o = ctrlD.usesRs2;

    // room downstream, no RAW on a source, tracker has a free slot
    assign canAccept = (!issueValid_o || issueReady_i) && !hazard_i && !trackFull_i;
    assign fetchReady_o = canAccept;
    assign accept = fetchValid_i && canAccept;

    // only real register writers occupy a tracker entry
    assign pushRd_o = fetch_i.inst.rType.rd;
    assign push_o = accept && ctrlD.regWr && (pushRd_o != 5'd0);

    assign issueD = '{
        ctrl:   ctrlD,
        pc:     fetch_i.pc,
        rs1Val: rs1Data_i,
        rs2Val: rs2Data_i,
        rd:     fetch_i.inst.rType.rd
    };

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            issueValid_o <= 1'b0;
        end else if (accept) begin
            issueValid_o <= 1'b1;
        end else if (issueReady_i) begin
            issueValid_o <= 1'b0;
        end
    end

    // issue payload loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_o <= issueD;
        end
    end

endmodule

// ==== decode/instDecoder.sv ====
module instDecoder (
    input  rvIsaPkg::instWord_u inst_i,
    output pipePkg::ctrl_t      ctrl_o
);

    logic isBad;
    logic [6:0] shiftTop;

    // alt picks sub or sra from funct3
    function automatic pipePkg::aluOp_e mapAluOp(input logic [2:0] funct3, input logic alt);
        pipePkg::aluOp_e op;
        case (funct3)
            rvIsaPkg::f3AddSub: op = alt ? pipePkg::aluSub : pipePkg::aluAdd;
            rvIsaPkg::f3Sll:    op = pipePkg::aluSll;
            rvIsaPkg::f3Slt:    op = pipePkg::aluSlt;
            rvIsaPkg::f3Sltu:   op = pipePkg::aluSltu;
            rvIsaPkg::f3Xor:    op = pipePkg::aluXor;
            rvIsaPkg::f3SrlSra: op = alt ? pipePkg::aluSra : pipePkg::aluSrl;
            rvIsaPkg::f3Or:     op = pipePkg::aluOr;
            default:            op = pipePkg::aluAnd;
        endcase
        return op;
    endfunction

    // shift immediates carry funct7 in the upper imm bits
    assign shiftTop = inst_i.iType.imm12[11:5];

    always_comb begin
        ctrl_o = '0;
        ctrl_o.aluOp = pipePkg::aluAdd;
        ctrl_o.srcASel = pipePkg::srcRs1;
        ctrl_o.srcBSel = pipePkg::srcImm;
        isBad = 1'b0;
        case (inst_i.rType.opcode)
            rvIsaPkg::opOp: begin
                ctrl_o.usesRs1 = 1'b1;
                ctrl_o.usesRs2 = 1'b1;
                ctrl_o.regWr = 1'b1;
                ctrl_o.srcBSel = pipePkg::srcRs2;
                ctrl_o.aluOp = mapAluOp(inst_i.rType.funct3,
                                        inst_i.rType.funct7 == rvIsaPkg::f7Alt);
                if (inst_i.rType.funct7 == rvIsaPkg::f7Alt) begin
                    isBad = inst_i.rType.funct3 != rvIsaPkg::f3AddSub &&
                            inst_i.rType.funct3 != rvIsaPkg::f3SrlSra;
                end else begin
                    isBad = inst_i.rType.funct7 != rvIsaPkg::f7Base;
                end
            end
            rvIsaPkg::opImm: begin
                ctrl_o.usesRs1 = 1'b1;
                ctrl_o.regWr = 1'b1;
                ctrl_o.imm = {{20{inst_i.iType.imm12[11]}}, inst_i.iType.imm12};
                // only srai uses the alt bit
                ctrl_o.aluOp = mapAluOp(inst_i.iType.funct3,
                                        inst_i.iType.funct3 == rvIsaPkg::f3SrlSra &&
                                        shiftTop == rvIsaPkg::f7Alt);
                if (inst_i.iType.funct3 == rvIsaPkg::f3Sll) begin
                    isBad = shiftTop != rvIsaPkg::f7Base;
                end else if (inst_i.iType.funct3 == rvIsaPkg::f3SrlSra) begin
                    isBad = shiftTop != rvIsaPkg::f7Base && shiftTop != rvIsaPkg::f7Alt;
                end
            end
            rvIsaPkg::opLui: begin
                ctrl_o.regWr = 1'b1;
                ctrl_o.aluOp = pipePkg::aluPassB;
                ctrl_o.imm = {inst_i.uType.imm20, 12'b0};
            end
            rvIsaPkg::opAuipc: begin
                ctrl_o.regWr = 1'b1;
                ctrl_o.srcASel = pipePkg::srcPc;
                ctrl_o.imm = {inst_i.uType.imm20, 12'b0};
            end
            default: isBad = 1'b1;
        endcase
        // illegal words read nothing and write nothing
        if (isBad) begin
            ctrl_o.usesRs1 = 1'b0;
            ctrl_o.usesRs2 = 1'b0;
            ctrl_o.regWr = 1'b0;
            ctrl_o.illegal = 1'b1;
        end
    end

endmodule

// ==== design/aluExec.sv ====
module aluExec (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                issueValid_i,
    output logic                issueReady_o,
    input  pipePkg::issuePkt_t  issue_i,
    output logic                resValid_o,
    input  logic                resReady_i,
    output pipePkg::resultPkt_t res_o
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluOut;
    logic [4:0] shamt;
    logic take;

    assign opA = (issue_i.ctrl.srcASel == pipePkg::srcPc) ? issue_i.pc : issue_i.rs1Val;
    assign opB = (issue_i.ctrl.srcBSel == pipePkg::srcImm) ? issue_i.ctrl.imm : issue_i.rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        case (issue_i.ctrl.aluOp)
            pipePkg::aluAdd:   aluOut = opA + opB;
            pipePkg::aluSub:   aluOut = opA - opB;
            pipePkg::aluSll:   aluOut = opA << shamt;
            pipePkg::aluSlt:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
            pipePkg::aluSltu:  aluOut = {31'd0, opA < opB};
            pipePkg::aluXor:   aluOut = opA ^ opB;
            pipePkg::aluSrl:   aluOut = opA >> shamt;
            pipePkg::aluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
            pipePkg::aluOr:    aluOut = opA | opB;
            pipePkg::aluAnd:   aluOut = opA & opB;
            default:           aluOut = opB;
        endcase
    end

    // output register empty or draining this cycle
    assign issueReady_o = !resValid_o || resReady_i;
    assign take = issueValid_i && issueReady_o;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            resValid_o <= 1'b0;
        end else if (take) begin
            resValid_o <= 1'b1;
        end else if (resReady_i) begin
            resValid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_o.pc <= issue_i.pc;
            res_o.rd <= issue_i.rd;
            res_o.value <= aluOut;
            res_o.regWr <= issue_i.ctrl.regWr;
            res_o.illegal <= issue_i.ctrl.illegal;
        end
    end

endmodule

// ==== design/coreTop.sv ====
module coreTop #(
    parameter int trackDepth = 4
) (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                fetchValid_i,
    output logic                fetchReady_o,
    input  pipePkg::fetchPkt_t  fetch_i,
    output logic                resValid_o,
    input  logic                resReady_i,
    output pipePkg::resultPkt_t res_o
);

    logic [4:0] rs1Addr;
    logic [4:0] rs2Addr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic hazard;
    logic trackFull;
    logic useRs1;
    logic useRs2;
    logic push;
    logic [4:0] pushRd;
    logic issueValid;
    logic issueReady;
    pipePkg::issuePkt_t issue;
    logic wbEn;

    // writeback and tracker release on the result transfer
    assign wbEn = resValid_o && resReady_i && res_o.regWr && (res_o.rd != 5'd0);

    decodeStage uDecode (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .fetchValid_i (fetchValid_i),
        .fetchReady_o (fetchReady_o),
        .fetch_i      (fetch_i),
        .rs1Addr_o    (rs1Addr),
        .rs2Addr_o    (rs2Addr),
        .rs1Data_i    (rs1Data),
        .rs2Data_i    (rs2Data),
        .hazard_i     (hazard),
        .trackFull_i  (trackFull),
        .useRs1_o     (useRs1),
        .useRs2_o     (useRs2),
        .push_o       (push),
        .pushRd_o     (pushRd),
        .issueValid_o (issueValid),
        .issueReady_i (issueReady),
        .issue_o      (issue)
    );

    regFile uRegFile (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .rdAddrA_i (rs1Addr),
        .rdAddrB_i (rs2Addr),
        .rdDataA_o (rs1Data),
        .rdDataB_o (rs2Data),
        .wrEn_i    (wbEn),
        .wrAddr_i  (res_o.rd),
        .wrData_i  (res_o.value)
    );

    writeTracker #(
        .trackDepth (trackDepth)
    ) uTracker (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .srcA_i   (rs1Addr),
        .srcB_i   (rs2Addr),
        .useA_i   (useRs1),
        .useB_i   (useRs2),
        .push_i   (push),
        .pushRd_i (pushRd),
        .pop_i    (wbEn),
        .hazard_o (hazard),
        .full_o   (trackFull)
    );

    aluExec uAlu (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .issueValid_i (issueValid),
        .issueReady_o (issueReady),
        .issue_i      (issue),
        .resValid_o   (resValid_o),
        .resReady_i   (resReady_i),
        .res_o        (res_o)
    );

endmodule

// ==== design/regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic [4:0]  rdAddrA_i,
    input  logic [4:0]  rdAddrB_i,
    output logic [31:0] rdDataA_o,
    output logic [31:0] rdDataB_o,
    input  logic        wrEn_i,
    input  logic [4:0]  wrAddr_i,
    input  logic [31:0] wrData_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != 5'd0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // x0 always reads zero
    assign rdDataA_o = (rdAddrA_i == 5'd0) ? 32'd0 : regs[rdAddrA_i];
    assign rdDataB_o = (rdAddrB_i == 5'd0) ? 32'd0 : regs[rdAddrB_i];

endmodule

// ==== design/writeTracker.sv ====
module writeTracker #(
    parameter int trackDepth = 4
) (
    input  logic       clk,
    input  logic       rstN_i,
    input  logic [4:0] srcA_i,
    input  logic [4:0] srcB_i,
    input  logic       useA_i,
    input  logic       useB_i,
    input  logic       push_i,
    input  logic [4:0] pushRd_i,
    input  logic       pop_i,
    output logic       hazard_o,
    output logic       full_o
);

    localparam int ptrW = (trackDepth > 1) ? $clog2(trackDepth) : 1;
    localparam int cntW = $clog2(trackDepth + 1);
    localparam logic [ptrW-1:0] lastIdx = ptrW'(trackDepth - 1);

    logic [4:0] entryRd [trackDepth];
    logic [trackDepth-1:0] entryValid;
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            entryValid <= '0;
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pop_i) begin
                entryValid[rdPtr] <= 1'b0;
                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
            end
            if (push_i) begin
                entryValid[wrPtr] <= 1'b1;
                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entryRd[wrPtr] <= pushRd_i;
        end
    end

    always_comb begin
        hazard_o = 1'b0;
        for (int i = 0; i < trackDepth; i++) begin
            if (entryValid[i] && ((useA_i && srcA_i == entryRd[i]) ||
                                  (useB_i && srcB_i == entryRd[i]))) begin
                hazard_o = 1'b1;
            end
        end
    end

    assign full_o = (count == cntW'(trackDepth));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module coreTb -f sources.f -o coreSim &&
    ./obj_dir/coreSim | tee /dev/stderr | grep -qx '>>> PASS' &&
    exit 0 || exit 1

// ==== sources.f ====
common/rvIsaPkg.sv
common/pipePkg.sv
decode/instDecoder.sv
decode/decodeStage.sv
design/regFile.sv
design/writeTracker.sv
design/aluExec.sv
design/coreTop.sv
tests/coreTop_checker.sv
tests/coreMonitor.sv
tests/coreTb.sv

// ==== tests/aluCases.mem ====
// columns: case id, pc, instruction, expected rd, expected value, expected illegal (all hex)
// value is ignored on illegal rows, a case id of ffffffff ends the list
01 00000100 00500093 01 00000005 0  // addi x1, x0, 5
02 00000104 ffd00113 02 fffffffd 0  // addi x2, x0, -3
03 00000108 002081b3 03 00000002 0  // add  x3, x1, x2
04 0000010c 40208233 04 00000008 0  // sub  x4, x1, x2
05 00000110 003092b3 05 00000014 0  // sll  x5, x1, x3
06 00000114 00112333 06 00000001 0  // slt  x6, x2, x1
07 00000118 001133b3 07 00000000 0  // sltu x7, x2, x1
08 0000011c 0020c433 08 fffffff8 0  // xor  x8, x1, x2
09 00000120 001154b3 09 07ffffff 0  // srl  x9, x2, x1
0a 00000124 40115533 0a ffffffff 0  // sra  x10, x2, x1
0b 00000128 0020e5b3 0b fffffffd 0  // or   x11, x1, x2
0c 0000012c 0020f633 0c 00000005 0  // and  x12, x1, x2
0d 00000130 00409693 0d 00000050 0  // slli x13, x1, 4
0e 00000134 40115713 0e fffffffe 0  // srai x14, x2, 1
0f 00000138 01c15793 0f 0000000f 0  // srli x15, x2, 28
10 0000013c 0060a813 10 00000001 0  // slti x16, x1, 6
11 00000140 fff0b893 11 00000001 0  // sltiu x17, x1, -1
12 00000144 fff0c913 12 fffffffa 0  // xori x18, x1, -1
13 00000148 7f00e993 13 000007f5 0  // ori  x19, x1, 0x7f0
14 0000014c 0ff17a13 14 000000fd 0  // andi x20, x2, 0xff
15 00000150 12345ab7 15 12345000 0  // lui  x21, 0x12345
16 00000154 00001b17 16 00001154 0  // auipc x22, 0x1
17 00000158 00708013 00 0000000c 0  // addi x0, x1, 7
18 0000015c 01500bb3 17 12345000 0  // add  x23, x0, x21
19 00000160 0000a603 0c 00000000 1  // lw x12, 0(x1), not supported
1a 00000164 00060c33 18 00000005 0  // add  x24, x12, x0
1b 00000168 001c0c93 19 00000006 0  // addi x25, x24, 1
1c 0000016c 019c8cb3 19 0000000c 0  // add  x25, x25, x25
1d 00000170 418c8d33 1a 00000007 0  // sub  x26, x25, x24
ffffffff 00000000 00000000 00 00000000 0

// ==== tests/coreMonitor.sv ====
module coreMonitor (
    input  logic                clk,
    input  logic                rstN_i,
    // one expected-value strobe per case
    input  logic                expValid_i,
    input  logic [31:0]         expId_i,
    input  logic [31:0]         expPc_i,
    input  logic [4:0]          expRd_i,
    input  logic [31:0]         expValue_i,
    input  logic                expIllegal_i,
    // observed result stream
    input  logic                resValid_i,
    input  logic                resReady_i,
    input  pipePkg::resultPkt_t res_i,
    output int                  checkedCnt_o,
    output int                  failCnt_o
);

    typedef struct packed {
        logic [31:0] id;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        illegal;
    } expect_t;

    expect_t expQ [$];
    expect_t cur;
    int bad;

    function automatic int compareField(input string name, input logic [31:0] id,
                                        input logic [31:0] expVal, input logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("CHECK FAILED case %0d %s expected %h got %h", id, name, expVal, actVal);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        if (!rstN_i) begin
            checkedCnt_o = 0;
            failCnt_o = 0;
        end else begin
            if (expValid_i) begin
                expQ.push_back('{expId_i, expPc_i, expRd_i, expValue_i, expIllegal_i});
            end
            if (resValid_i && resReady_i) begin
                if (expQ.size() == 0) begin
                    $display("result at pc %h arrived with no case left to compare", res_i.pc);
                    failCnt_o = failCnt_o + 1;
                end else begin
                    cur = expQ.pop_front();
                    bad = 0;
                    bad += compareField("res_o.pc", cur.id, cur.pc, res_i.pc);
                    bad += compareField("res_o.rd", cur.id, 32'(cur.rd), 32'(res_i.rd));
                    bad += compareField("res_o.illegal", cur.id, 32'(cur.illegal),
                                        32'(res_i.illegal));
                    bad += compareField("res_o.regWr", cur.id, 32'(!cur.illegal),
                                        32'(res_i.regWr));
                    // value of an illegal word is undefined
                    if (!cur.illegal) begin
                        bad += compareField("res_o.value", cur.id, cur.value, res_i.value);
                    end
                    checkedCnt_o = checkedCnt_o + 1;
                    if (bad != 0) begin
                        failCnt_o = failCnt_o + 1;
                        $display("case %0d at pc %h failed", cur.id, cur.pc);
                    end else begin
                        $display("case %0d at pc %h ok", cur.id, cur.pc);
                    end
                end
            end
        end
    end

endmodule

// ==== tests/coreTb.sv ====
module coreTb;

    localparam int maxCases = 64;
    localparam int fieldCnt = 6;
    localparam int readyTimeout = 200;
    localparam int drainTimeout = 500;

    logic clk;
    logic rstN;
    logic fetchValid;
    logic fetchReady;
    pipePkg::fetchPkt_t fetchPkt;
    logic resValid;
    logic resReady;
    pipePkg::resultPkt_t resPkt;

    logic expValid;
    logic [31:0] expId;
    logic [31:0] expPc;
    logic [4:0] expRd;
    logic [31:0] expValue;
    logic expIllegal;
    int checkedCnt;
    int failCnt;

    logic [31:0] caseMem [maxCases * fieldCnt];
    logic [31:0] lcgState;
    logic [31:0] gapRand;
    logic timedOut;
    int numCases;
    int waitCnt;

    // two entries match the decode and execute registers, so full is reached
    coreTop #(
        .trackDepth (2)
    ) dut (
        .clk          (clk),
        .rstN_i       (rstN),
        .fetchValid_i (fetchValid),
        .fetchReady_o (fetchReady),
        .fetch_i      (fetchPkt),
        .resValid_o   (resValid),
        .resReady_i   (resReady),
        .res_o        (resPkt)
    );

    coreMonitor resultCheck (
        .clk          (clk),
        .rstN_i       (rstN),
        .expValid_i   (expValid),
        .expId_i      (expId),
        .expPc_i      (expPc),
        .expRd_i      (expRd),
        .expValue_i   (expValue),
        .expIllegal_i (expIllegal),
        .resValid_i   (resValid),
        .resReady_i   (resReady),
        .res_i        (resPkt),
        .checkedCnt_o (checkedCnt),
        .failCnt_o    (failCnt)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // step to the next falling edge and redraw result back-pressure
    task automatic nextCycle();
        logic [31:0] r;
        @(negedge clk);
        r = nextRand();
        resReady = (r[31:30] != 2'b00);
        expValid = 1'b0;
    endtask

    task automatic driveCase(input int idx);
        int base;
        base = idx * fieldCnt;
        fetchPkt.pc = caseMem[base + 1];
        fetchPkt.inst = caseMem[base + 2];
        fetchValid = 1'b1;
        expId = caseMem[base];
        expPc = caseMem[base + 1];
        expRd = caseMem[base + 3][4:0];
        expValue = caseMem[base + 4];
        expIllegal = caseMem[base + 5][0];
        expValid = 1'b1;
    endtask

    task automatic waitAccept(input int idx);
        int cycles;
        logic taken;
        cycles = 0;
        taken = 1'b0;
        while (!taken && !timedOut) begin
            @(posedge clk);
            if (fetchReady) begin
                taken = 1'b1;
            end else begin
                cycles++;
                if (cycles > readyTimeout) begin
                    $display("timeout waiting for fetchReady_o on case index %0d", idx);
                    timedOut = 1'b1;
                end
            end
            nextCycle();
        end
        fetchValid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        fetchValid = 1'b0;
        fetchPkt = '0;
        resReady = 1'b0;
        expValid = 1'b0;
        expId = '0;
        expPc = '0;
        expRd = '0;
        expValue = '0;
        expIllegal = 1'b0;
        lcgState = 32'hf8b00e25;
        timedOut = 1'b0;

        $readmemh("tests/aluCases.mem", caseMem);
        numCases = 0;
        while (numCases < maxCases && caseMem[numCases * fieldCnt] != 32'hffffffff) begin
            numCases++;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int k = 0; k < numCases && !timedOut; k++) begin
            // occasional idle cycle on the fetch stream
            gapRand = nextRand();
            if (gapRand[31:29] == 3'b000) begin
                nextCycle();
            end
            driveCase(k);
            waitAccept(k);
        end

        waitCnt = 0;
        while (!timedOut && checkedCnt < numCases) begin
            nextCycle();
            waitCnt++;
            if (waitCnt > drainTimeout) begin
                $display("timeout waiting for the last result, %0d of %0d received",
                         checkedCnt, numCases);
                timedOut = 1'b1;
            end
        end
        // extra results would show up here
        repeat (10) nextCycle();

        $display("%0d of %0d cases checked, %0d failed", checkedCnt, numCases, failCnt);
        if (!timedOut && failCnt == 0 && checkedCnt == numCases) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/coreTop_checker.sv ====
module coreTop_checker (
    input logic                clk,
    input logic                rstN_i,
    input logic                fetchValid_i,
    input logic                fetchReady_i,
    input pipePkg::fetchPkt_t  fetch_i,
    input logic                resValid_i,
    input logic                resReady_i,
    input pipePkg::resultPkt_t res_i,
    input logic                push_i,
    input logic                pop_i,
    input logic                trackFull_i
);

    // a stalled fetch keeps its word and pc
    fetchHold: assert property (@(posedge clk) disable iff (!rstN_i)
        fetchValid_i && !fetchReady_i |=> fetchValid_i && $stable(fetch_i))
        else $error("fetch stream dropped or changed before the transfer");

    resHold: assert property (@(posedge clk) disable iff (!rstN_i)
        resValid_i && !resReady_i |=> resValid_i && $stable(res_i))
        else $error("result stream dropped or changed before the transfer");

    // occupancy only reaches depth through a push without a pop
    fullOnlyAfterPush: assert property (@(posedge clk) disable iff (!rstN_i)
        $rose(trackFull_i) |-> $past(push_i && !pop_i))
        else $error("tracker became full without a push");

    resIdleAfterReset: assert property (@(posedge clk)
        $rose(rstN_i) |-> !resValid_i)
        else $error("result valid high right after reset");

endmodule

bind coreTop coreTop_checker uChecker (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .fetchValid_i (fetchValid_i),
    .fetchReady_i (fetchReady_o),
    .fetch_i      (fetch_i),
    .resValid_i   (resValid_o),
    .resReady_i   (resReady_i),
    .res_i        (res_o),
    .push_i       (push),
    .pop_i        (wbEn),
    .trackFull_i  (trackFull)
);
